// File: bench/eeprom_tests.txt
# name  is_read  word_addr  wdata  present  exp_rdata  exp_nack   (hex: addr, wdata, rdata)
# is_read: 0 write, 1 read, 2 write with a second request while busy
rd_fill_00    1 00 00 1 5a 0
wr_00         0 00 c3 1 00 0
rd_00         1 00 00 1 c3 0
wr_ff         0 ff 3c 1 00 0
rd_ff         1 ff 00 1 3c 0
wr_7e         0 7e a5 1 00 0
rd_7e         1 7e 00 1 a5 0
rd_fill_12    1 12 00 1 48 0
wr_absent     0 40 11 0 00 1
rd_absent     1 40 00 0 00 1
rd_after_abs  1 40 00 1 1a 0
wr_busy_81    2 81 96 1 00 0
rd_busy_81    1 81 00 1 96 0

// File: files.f
src/i2c_pkg.sv
src/scl_timer.sv
src/xfer_sequencer.sv
src/line_driver.sv
src/eeprom_ctrl.sv
bench/eeprom_model.sv
bench/eeprom_ctrl_tb.sv

// File: Makefile
TB   := eeprom_ctrl_tb
BIN  := obj_dir/V$(TB)
SRCS := $(shell cat files.f)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'NO ERRORS'

$(BIN): files.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps -f files.f --top-module $(TB) -Mdir obj_dir

clean:
	rm -rf obj_dir

// File: bench/eeprom_ctrl_tb.sv
`timescale 1ns/1ps

module eeprom_ctrl_tb;

        localparam int QCYC    = 4;
        localparam int BIT_CYC = 4 * QCYC;

        // kind 0 write, 1 read, 2 write with a second request while busy
        typedef struct packed {
                logic [1:0] kind;
                logic [7:0] addr;
                logic [7:0] wdata;
                logic       present;
                logic [7:0] exp_rdata;
                logic       exp_nack;
        } test_vec_t;

        logic               s_clk;
        logic               s_rst_n;
        logic               req;
        i2c_pkg::xfer_req_t req_data;
        logic               busy;
        logic               done;
        i2c_pkg::xfer_rsp_t rsp;
        logic               scl;
        logic               sda_pull;
        logic               slave_pull;
        logic               sda;
        logic               present;
        int                 start_cnt;
        int                 stop_cnt;
        int                 bus_errs;
        int                 errors;
        int                 n_tests;
        test_vec_t          vecs [$];
        logic [127:0]       names [$];

        // wired-AND of the two open-drain pulls
        assign sda = !(sda_pull || slave_pull);

        eeprom_ctrl #(
                .QUARTER_CYC (QCYC),
                .DEV_ADDR    (7'h50)
        ) uut (
                .s_clk    (s_clk),
                .s_rst_n  (s_rst_n),
                .req      (req),
                .req_data (req_data),
                .busy     (busy),
                .done     (done),
                .rsp      (rsp),
                .scl      (scl),
                .sda_pull (sda_pull),
                .sda_in   (sda)
        );

        eeprom_model #(
                .DEV_ADDR (7'h50)
        ) u_eeprom (
                .rst_n     (s_rst_n),
                .present   (present),
                .scl       (scl),
                .sda       (sda),
                .sda_pull  (slave_pull),
                .start_cnt (start_cnt),
                .stop_cnt  (stop_cnt),
                .bus_errs  (bus_errs)
        );

        initial begin
                s_clk = 1'b0;
                forever #10 s_clk = ~s_clk;
        end

        task automatic expect_equal(input logic [127:0] name, input string what,
                                    input int exp, input int act);
                assert (exp == act) else begin
                        errors++;
                        $display("FAILED %0s %0s: expected %0h, actual %0h", name, what, exp, act);
                end
        endtask

        task automatic load_tests();
                int           fd;
                int           n;
                int           kind;
                int           pres;
                int           nack;
                string        line;
                logic [127:0] name;
                logic [7:0]   addr;
                logic [7:0]   wdata;
                logic [7:0]   rdata;
                test_vec_t    v;
                fd = $fopen("bench/eeprom_tests.txt", "r");
                assert (fd != 0) else begin
                        errors++;
                        $display("could not open the test file bench/eeprom_tests.txt");
                end
                while (fd != 0 && $fgets(line, fd) != 0) begin
                        if (line.len() > 1 && line.getc(0) != "#") begin
                                n = $sscanf(line, "%s %d %h %h %d %h %d",
                                            name, kind, addr, wdata, pres, rdata, nack);
                                assert (n == 7) else begin
                                        errors++;
                                        $display("test line has %0d fields instead of 7", n);
                                end
                                v.kind      = kind[1:0];
                                v.addr      = addr;
                                v.wdata     = wdata;
                                v.present   = (pres != 0);
                                v.exp_rdata = rdata;
                                v.exp_nack  = (nack != 0);
                                if (n == 7) begin
                                        vecs.push_back(v);
                                        names.push_back(name);
                                end
                        end
                end
                if (fd != 0) begin
                        $fclose(fd);
                end
        endtask

        task automatic run_test(input logic [127:0] name, input test_vec_t v);
                int starts0;
                int stops0;
                int exp_starts;
                int wait_cyc;
                bit seen;
                @(posedge s_clk);
                present            <= v.present;
                req                <= 1'b1;
                req_data.is_read   <= (v.kind == 2'd1);
                req_data.word_addr <= v.addr;
                req_data.wdata     <= v.wdata;
                starts0 = start_cnt;
                stops0  = stop_cnt;
                @(posedge s_clk);
                req <= 1'b0;
                @(posedge s_clk);
                expect_equal(name, "busy after req", 1, int'(busy));
                if (v.kind == 2'd2) begin
                        // should be dropped by the sequencer
                        repeat (BIT_CYC) @(posedge s_clk);
                        req            <= 1'b1;
                        req_data.wdata <= ~v.wdata;
                        @(posedge s_clk);
                        req <= 1'b0;
                end
                wait_cyc = 0;
                seen     = 1'b0;
                while (!seen && wait_cyc < 2 * 39 * BIT_CYC) begin
                        @(posedge s_clk);
                        seen = done;
                        wait_cyc++;
                end
                assert (seen) else begin
                        errors++;
                        $display("%0s: done did not arrive within %0d cycles", name, wait_cyc);
                end
                if (seen) begin
                        expect_equal(name, "nack", int'(v.exp_nack), int'(rsp.nack));
                        if (v.kind == 2'd1 && !v.exp_nack) begin
                                expect_equal(name, "rdata", int'(v.exp_rdata), int'(rsp.rdata));
                        end
                        expect_equal(name, "busy at done", 0, int'(busy));
                        expect_equal(name, "scl at done", 1, int'(scl));
                        expect_equal(name, "sda_pull at done", 0, int'(sda_pull));
                        exp_starts = (v.kind == 2'd1 && v.present) ? 2 : 1;
                        expect_equal(name, "start count", exp_starts, start_cnt - starts0);
                        assert (stop_cnt - stops0 == 1) else begin
                                errors++;
                                $display("%0s: transaction ended with %0d stop conditions",
                                         name, stop_cnt - stops0);
                        end
                end
                // exactly one done per accepted request
                repeat (2 * BIT_CYC) begin
                        @(posedge s_clk);
                        assert (!done && !busy) else begin
                                errors++;
                                $display("%0s: extra activity after done", name);
                        end
                end
        endtask

        initial begin
                errors   = 0;
                n_tests  = 0;
                s_rst_n  = 1'b0;
                req      = 1'b0;
                req_data = '0;
                present  = 1'b0;
                load_tests();
                n_tests = vecs.size();
                repeat (5) @(posedge s_clk);
                s_rst_n <= 1'b1;
                @(posedge s_clk);
                expect_equal("reset", "scl", 1, int'(scl));
                expect_equal("reset", "sda_pull", 0, int'(sda_pull));
                expect_equal("reset", "busy", 0, int'(busy));
                expect_equal("reset", "done", 0, int'(done));
                foreach (vecs[i]) begin
                        run_test(names[i], vecs[i]);
                end
                $display("%0d check errors, %0d bus errors", errors, bus_errs);
                if (errors == 0 && bus_errs == 0) begin
                        $display("NO ERRORS");
                end else begin
                        $display("ERRORS FOUND");
                end
                $finish;
        end

        initial begin
                wait (n_tests > 0);
                #(longint'(n_tests) * 39 * BIT_CYC * 20 * 3);
                $display("watchdog expired before the tests finished");
                $display("%0d check errors, %0d bus errors", errors, bus_errs);
                $display("ERRORS FOUND");
                $finish;
        end

endmodule

// File: bench/eeprom_model.sv
`timescale 1ns/1ps

module eeprom_model #(
        parameter logic [6:0] DEV_ADDR = 7'h50
) (
        input  logic rst_n,
        input  logic present,
        input  logic scl,
        input  logic sda,
        output logic sda_pull,
        output int   start_cnt,
        output int   stop_cnt,
        output int   bus_errs
);

        logic [7:0] mem [256];
        logic [7:0] shift;
        logic [7:0] ptr;
        logic       pull_q;
        logic       scl_q;
        logic       sda_q;
        logic       active;
        logic       sending;
        logic       rd;
        logic       nacked;
        int         bit_cnt;
        int         byte_no;

        // slave output lags the clock edge a little
        assign #5 sda_pull = pull_q;

        initial begin
                for (int i = 0; i < 256; i++) begin
                        mem[i[7:0]] = i[7:0] ^ 8'h5a;
                end
                pull_q    = 1'b0;
                active    = 1'b0;
                scl_q     = 1'b1;
                sda_q     = 1'b1;
                start_cnt = 0;
                stop_cnt  = 0;
                bus_errs  = 0;
        end

        // the slave changes its data output on the falling clock
        task automatic clock_fall();
                logic ack;
                ack = 1'b1;
                if (bit_cnt == 8 && sending) begin
                        // master acknowledge slot
                        pull_q = 1'b0;
                end else if (bit_cnt == 8) begin
                        if (byte_no == 0) begin
                                ack = present && shift[7:1] == DEV_ADDR;
                                rd  = shift[0];
                        end else if (byte_no == 1) begin
                                ptr = shift;
                        end else begin
                                mem[ptr] = shift;
                                ptr      = ptr + 8'd1;
                        end
                        byte_no++;
                        pull_q = ack;
                        active = ack;
                end else if (bit_cnt == 9) begin
                        bit_cnt = 0;
                        pull_q  = 1'b0;
                        if (sending && nacked) begin
                                active = 1'b0;
                        end else if (sending || (byte_no == 1 && rd)) begin
                                shift   = mem[ptr];
                                ptr     = ptr + 8'd1;
                                sending = 1'b1;
                                pull_q  = !shift[7];
                        end
                end else if (sending) begin
                        shift  = shift << 1;
                        pull_q = !shift[7];
                end
        endtask

        always @(scl or sda) begin
                if (rst_n && scl != scl_q && sda != sda_q) begin
                        bus_errs++;
                        $display("bus error: data and clock changed together at %0t", $time);
                end else if (rst_n && sda != sda_q && scl) begin
                        if (sda) begin
                                stop_cnt++;
                                active = 1'b0;
                                pull_q = 1'b0;
                        end else begin
                                start_cnt++;
                                active  = 1'b1;
                                sending = 1'b0;
                                bit_cnt = 0;
                                byte_no = 0;
                        end
                end else if (active && scl && !scl_q) begin
                        if (!sending && bit_cnt < 8) begin
                                shift = {shift[6:0], sda};
                        end
                        if (sending && bit_cnt == 8) begin
                                nacked = sda;
                        end
                        bit_cnt++;
                end else if (active && !scl && scl_q) begin
                        clock_fall();
                end
                scl_q = scl;
                sda_q = sda;
        end

endmodule

// File: src/eeprom_ctrl.sv
`timescale 1ns/1ps

module eeprom_ctrl #(
        parameter int                             QUARTER_CYC = 62,
        parameter logic [i2c_pkg::DEV_ADDR_W-1:0] DEV_ADDR    = 7'h50
) (
        input  logic               s_clk,
        input  logic               s_rst_n,
        input  logic               req,
        input  i2c_pkg::xfer_req_t req_data,
        output logic               busy,
        output logic               done,
        output i2c_pkg::xfer_rsp_t rsp,
        output logic               scl,
        output logic               sda_pull,
        input  logic               sda_in
);

        i2c_pkg::quarter_t quarter;
        i2c_pkg::bit_cmd_t bit_cmd;
        logic              rbit;

        // timer runs for the whole transaction
        scl_timer #(
                .QUARTER_CYC(QUARTER_CYC)
        ) u_timer (
                .s_clk   (s_clk),
                .s_rst_n (s_rst_n),
                .run     (busy),
                .quarter (quarter)
        );

        xfer_sequencer #(
                .DEV_ADDR(DEV_ADDR)
        ) u_seq (
                .s_clk    (s_clk),
                .s_rst_n  (s_rst_n),
                .req      (req),
                .req_data (req_data),
                .quarter  (quarter),
                .rbit     (rbit),
                .bit_cmd  (bit_cmd),
                .busy     (busy),
                .done     (done),
                .rsp      (rsp)
        );

        line_driver u_drv (
                .s_clk    (s_clk),
                .s_rst_n  (s_rst_n),
                .quarter  (quarter),
                .bit_cmd  (bit_cmd),
                .sda_in   (sda_in),
                .scl      (scl),
                .sda_pull (sda_pull),
                .rbit     (rbit)
        );

endmodule

// File: src/line_driver.sv
`timescale 1ns/1ps

module line_driver (
        input  logic              s_clk,
        input  logic              s_rst_n,
        input  i2c_pkg::quarter_t quarter,
        input  i2c_pkg::bit_cmd_t bit_cmd,
        input  logic              sda_in,
        output logic              scl,
        output logic              sda_pull,
        output logic              rbit
);

        logic clk_hi;
        logic scl_nxt;
        logic pull_nxt;
        logic sda_sync;
        logic is_idle;

        // clock high in the two middle quarters
        assign clk_hi  = (quarter.q_idx == 2'd1) || (quarter.q_idx == 2'd2);
        assign is_idle = (bit_cmd.op == i2c_pkg::OP_IDLE);

        always_comb begin
                scl_nxt  = 1'b1;
                pull_nxt = 1'b0;
                case (bit_cmd.op)
                        i2c_pkg::OP_START: begin
                                // falling data while clock high
                                scl_nxt  = clk_hi;
                                pull_nxt = quarter.q_idx[1];
                        end
                        i2c_pkg::OP_WRITE: begin
                                scl_nxt  = clk_hi;
                                pull_nxt = !bit_cmd.wbit;
                        end
                        i2c_pkg::OP_READ: begin
                                scl_nxt  = clk_hi;
                                pull_nxt = 1'b0;
                        end
                        i2c_pkg::OP_STOP: begin
                                // clock stays high through quarter 3
                                scl_nxt  = (quarter.q_idx != 2'd0);
                                pull_nxt = !quarter.q_idx[1];
                        end
                        default: begin
                                scl_nxt  = 1'b1;
                                pull_nxt = 1'b0;
                        end
                endcase
        end

        always_ff @(posedge s_clk or negedge s_rst_n) begin
                if (!s_rst_n) begin
                        scl      <= 1'b1;
                        sda_pull <= 1'b0;
                        sda_sync <= 1'b1;
                        rbit     <= 1'b1;
                end else begin
                        sda_sync <= sda_in;
                        if (quarter.q_start || is_idle) begin
                                scl      <= scl_nxt;
                                sda_pull <= pull_nxt;
                        end
                        if (quarter.q_start && quarter.q_idx == 2'd2) begin
                                rbit <= sda_sync;
                        end
                end
        end

endmodule

// File: src/xfer_sequencer.sv
`timescale 1ns/1ps

module xfer_sequencer #(
        parameter logic [i2c_pkg::DEV_ADDR_W-1:0] DEV_ADDR = 7'h50
) (
        input  logic               s_clk,
        input  logic               s_rst_n,
        input  logic               req,
        input  i2c_pkg::xfer_req_t req_data,
        input  i2c_pkg::quarter_t  quarter,
        input  logic               rbit,
        output i2c_pkg::bit_cmd_t  bit_cmd,
        output logic               busy,
        output logic               done,
        output i2c_pkg::xfer_rsp_t rsp
);

        localparam int W = i2c_pkg::WORD_W;
        localparam int BIT_W = $clog2(W + 1);
        localparam logic [BIT_W-1:0] ACK_SLOT = BIT_W'(W);

        typedef enum logic [2:0] {
                PH_IDLE,
                PH_START,
                PH_WBYTE,
                PH_RSTART,
                PH_RBYTE,
                PH_STOP
        } phase_t;

        phase_t             phase;
        logic [BIT_W-1:0]   bit_cnt;
        logic [1:0]         byte_idx;
        logic [W-1:0]       shreg;
        i2c_pkg::xfer_req_t req_q;
        logic               nack_q;
        logic               ack_slot;
        logic               accept;

        // ninth bit of a byte
        assign ack_slot = (bit_cnt == ACK_SLOT);
        assign accept   = (phase == PH_IDLE) && req;
        assign busy     = (phase != PH_IDLE);

        always_comb begin
                bit_cmd.op   = i2c_pkg::OP_IDLE;
                bit_cmd.wbit = 1'b1;
                case (phase)
                        PH_START, PH_RSTART: bit_cmd.op = i2c_pkg::OP_START;
                        PH_WBYTE: begin
                                if (ack_slot) begin
                                        bit_cmd.op = i2c_pkg::OP_READ;
                                end else begin
                                        bit_cmd.op   = i2c_pkg::OP_WRITE;
                                        bit_cmd.wbit = shreg[W-1];
                                end
                        end
                        // wbit stays high in the ack slot for a not-acknowledge
                        PH_RBYTE: bit_cmd.op = ack_slot ? i2c_pkg::OP_WRITE : i2c_pkg::OP_READ;
                        PH_STOP:  bit_cmd.op = i2c_pkg::OP_STOP;
                        default:  bit_cmd.op = i2c_pkg::OP_IDLE;
                endcase
        end

        always_ff @(posedge s_clk or negedge s_rst_n) begin
                if (!s_rst_n) begin
                        phase    <= PH_IDLE;
                        bit_cnt  <= '0;
                        byte_idx <= '0;
                        nack_q   <= 1'b0;
                        done     <= 1'b0;
                        rsp      <= '0;
                end else begin
                        done <= 1'b0;
                        if (accept) begin
                                phase    <= PH_START;
                                bit_cnt  <= '0;
                                byte_idx <= '0;
                                nack_q   <= 1'b0;
                        end else if (quarter.bit_done) begin
                                case (phase)
                                        PH_START, PH_RSTART: begin
                                                phase   <= PH_WBYTE;
                                                bit_cnt <= '0;
                                        end
                                        PH_WBYTE: begin
                                                if (!ack_slot) begin
                                                        bit_cnt <= bit_cnt + 1'b1;
                                                end else if (rbit) begin
                                                        // no acknowledge so the transfer ends
                                                        nack_q <= 1'b1;
                                                        phase  <= PH_STOP;
                                                end else begin
                                                        bit_cnt  <= '0;
                                                        byte_idx <= byte_idx + 2'd1;
                                                        if (byte_idx == 2'd1 && req_q.is_read) begin
                                                                phase <= PH_RSTART;
                                                        end else if (byte_idx == 2'd2) begin
                                                                phase <= req_q.is_read ? PH_RBYTE
                                                                                       : PH_STOP;
                                                        end
                                                end
                                        end
                                        PH_RBYTE: begin
                                                if (!ack_slot) begin
                                                        bit_cnt <= bit_cnt + 1'b1;
                                                end else begin
                                                        phase <= PH_STOP;
                                                end
                                        end
                                        PH_STOP: begin
                                                phase      <= PH_IDLE;
                                                done       <= 1'b1;
                                                rsp.rdata  <= req_q.is_read ? shreg : '0;
                                                rsp.nack   <= nack_q;
                                        end
                                        default: phase <= PH_IDLE;
                                endcase
                        end
                end
        end

        // request and shift register
        always_ff @(posedge s_clk) begin
                if (accept) begin
                        req_q <= req_data;
                        shreg <= {DEV_ADDR, i2c_pkg::CTRL_WR};
                end else if (quarter.bit_done) begin
                        if (phase == PH_WBYTE && !ack_slot) begin
                                shreg <= shreg << 1;
                        end else if (phase == PH_WBYTE && byte_idx == 2'd0) begin
                                shreg <= req_q.word_addr;
                        end else if (phase == PH_WBYTE && byte_idx == 2'd1) begin
                                shreg <= req_q.is_read ? {DEV_ADDR, i2c_pkg::CTRL_RD}
                                                       : req_q.wdata;
                        end else if (phase == PH_RBYTE && !ack_slot) begin
                                // msb first
                                shreg <= {shreg[W-2:0], rbit};
                        end
                end
        end

endmodule

// File: src/scl_timer.sv
`timescale 1ns/1ps

module scl_timer #(
        parameter int QUARTER_CYC = 62
) (
        input  logic              s_clk,
        input  logic              s_rst_n,
        input  logic              run,
        output i2c_pkg::quarter_t quarter
);

        localparam int CNT_W = $clog2(QUARTER_CYC + 1);
        localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(QUARTER_CYC - 1);

        logic [CNT_W-1:0] cyc_cnt;
        logic [1:0]       q_idx;
        logic             cyc_last;

        assign cyc_last = (cyc_cnt == CNT_LAST);

        always_ff @(posedge s_clk or negedge s_rst_n) begin
                if (!s_rst_n) begin
                        cyc_cnt <= '0;
                        q_idx   <= '0;
                end else if (!run) begin
                        // parked at quarter 0 between transactions
                        cyc_cnt <= '0;
                        q_idx   <= '0;
                end else if (cyc_last) begin
                        cyc_cnt <= '0;
                        q_idx   <= q_idx + 2'd1;
                end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                end
        end

        // strobes only while running
        assign quarter.q_start  = run && (cyc_cnt == '0);
        assign quarter.q_idx    = q_idx;
        assign quarter.bit_done = run && cyc_last && (q_idx == 2'd3);

endmodule

// File: src/i2c_pkg.sv
package i2c_pkg;

        parameter int WORD_W = 8;

        // 7-bit device address plus the r/w bit
        parameter int DEV_ADDR_W = 7;

        // r/w bit at the end of the control byte
        parameter logic CTRL_WR = 1'b0;
        parameter logic CTRL_RD = 1'b1;

        // what the bus does during one bit period
        typedef enum logic [2:0] {
                OP_IDLE,
                OP_START,
                OP_WRITE,
                OP_READ,
                OP_STOP
        } bit_op_t;

        typedef struct packed {
                bit_op_t op;
                logic    wbit;
        } bit_cmd_t;

        // quarter-bit strobes from the timer
        typedef struct packed {
                logic       q_start;
                logic [1:0] q_idx;
                logic       bit_done;
        } quarter_t;

        typedef struct packed {
                logic              is_read;
                logic [WORD_W-1:0] word_addr;
                logic [WORD_W-1:0] wdata;
        } xfer_req_t;

        typedef struct packed {
                logic [WORD_W-1:0] rdata;
                logic              nack;
        } xfer_rsp_t;

endpackage
